//--- router_two_stage.f
hw/router_pkg.sv
hw/rr_arbiter.sv
hw/input_port.sv
hw/switch_allocator.sv
hw/crossbar.sv
hw/router_two_stage.sv
tests/tb_router_two_stage.sv

//--- Makefile
SIM      := verilator
TOP      := tb_router_two_stage
FILELIST := router_two_stage.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

# pass only if the run prints the pass line
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_router_two_stage.sv
`timescale 1ns/1ps

module tb_router_two_stage;
    import router_pkg::*;

    localparam int buf_depth   = 4;
    localparam int my_x        = 2;
    localparam int my_y        = 2;
    localparam int hold_cycles = 40;  // credit_in withheld this long
    localparam int rr_pkts     = 6;

    typedef struct packed {
        int   port;
        int   dx;
        int   dy;
        int   len;
        int   gap;
        logic hold;
    } row_t;

    logic                 clk = 1'b0;
    logic                 arst_n = 1'b0;
    logic [coord_w-1:0]   cur_x = coord_w'(my_x);
    logic [coord_w-1:0]   cur_y = coord_w'(my_y);
    flit_t                flit_in [num_ports] = '{default: '0};
    logic [num_ports-1:0] flit_in_wr = '0;
    logic [num_ports-1:0] credit_out;
    flit_t                flit_out [num_ports];
    logic [num_ports-1:0] flit_out_wr;
    logic [num_ports-1:0] credit_in = '0;

    row_t        rows [$];
    flit_t       src_q [num_ports][$];              // flits waiting for upstream credit
    int          src_out [num_ports][$];
    flit_t       exp_q [num_ports*num_ports][$];    // per output and input
    int          src_seq [num_ports][$];            // input of each packet seen per output
    int          cur_src [num_ports] = '{default: -1};
    int          up_credit [num_ports] = '{default: buf_depth};
    int          wr_cnt [num_ports] = '{default: 0};
    int          cr_cnt [num_ports] = '{default: 0};
    int          pend_cr [num_ports] = '{default: 0};
    bit          hold_on [num_ports] = '{default: 1'b0};
    int          hold_cnt [num_ports] = '{default: 0};
    int          hold_left [num_ports] = '{default: 0};
    int          errors = 0;
    int          checks = 0;
    int          cycle = 0;
    int          limit = 100000;
    int          since_rst = 0;
    logic [31:0] lcg_state = 32'd20467;

    router_two_stage #(
        .buf_depth (buf_depth)
    ) uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .cur_x       (cur_x),
        .cur_y       (cur_y),
        .flit_in     (flit_in),
        .flit_in_wr  (flit_in_wr),
        .credit_out  (credit_out),
        .flit_out    (flit_out),
        .flit_out_wr (flit_out_wr),
        .credit_in   (credit_in)
    );

    always #10 clk = ~clk;

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // x first, then y
    function automatic int xy_port(int dx, int dy);
        if (dx > my_x) return port_east;
        if (dx < my_x) return port_west;
        if (dy > my_y) return port_south;
        if (dy < my_y) return port_north;
        return port_local;
    endfunction

    function automatic void add_row(int port, int dx, int dy, int len, int gap, logic hold);
        rows.push_back('{port, dx, dy, len, gap, hold});
    endfunction

    function automatic void queue_packet(row_t row);
        flit_t f;
        int    o;
        o = xy_port(row.dx, row.dy);
        for (int k = 0; k < row.len; k++) begin
            f.head = (k == 0);
            f.tail = (k == row.len - 1);
            if (k == 0) begin
                f.body.hdr.dst_x   = coord_w'(row.dx);
                f.body.hdr.dst_y   = coord_w'(row.dy);
                f.body.hdr.payload = head_payload_w'(next_rand());
            end else begin
                f.body.data = body_w'(next_rand());
            end
            src_q[row.port].push_back(f);
            src_out[row.port].push_back(o);
        end
        if (row.hold) begin
            hold_on[o]   = 1'b1;
            hold_cnt[o]  = 0;
            hold_left[o] = hold_cycles;
        end
    endfunction

    // a head picks its source queue, later flits must follow from the same one
    task automatic score_flit(int o, flit_t f);
        int src;
        src = cur_src[o];
        if (src < 0) begin
            for (int j = 0; j < num_ports; j++) begin
                if (src < 0 && exp_q[o*num_ports+j].size() > 0 && exp_q[o*num_ports+j][0] == f)
                    src = j;
            end
            if (src >= 0) src_seq[o].push_back(src);
            for (int j = 0; j < num_ports; j++) begin
                if (src < 0 && exp_q[o*num_ports+j].size() > 0) src = j;  // report vs oldest
            end
        end
        if (src < 0 || exp_q[o*num_ports+src].size() == 0) begin
            $display("flit %h left output %0d while no flit was expected there", f, o);
            errors++;
        end else begin
            check_value($sformatf("flit on output %0d", o), exp_q[o*num_ports+src][0], f);
            void'(exp_q[o*num_ports+src].pop_front());
            cur_src[o] = f.tail ? -1 : src;
        end
    endtask

    function automatic bit all_idle();
        for (int p = 0; p < num_ports; p++) begin
            if (src_q[p].size() != 0 || pend_cr[p] != 0 || hold_on[p]) return 1'b0;
            for (int j = 0; j < num_ports; j++)
                if (exp_q[p*num_ports+j].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    // upstream and downstream models, all inputs change here
    always @(negedge clk) begin : models
        flit_t f;
        int    o;
        if (!arst_n) begin
            check_value("reset flit_out_wr", 32'd0, 32'(flit_out_wr));
            check_value("reset credit_out", 32'd0, 32'(credit_out));
            since_rst  = 0;
            flit_in_wr = '0;
            credit_in  = '0;
        end else begin
            since_rst++;
            if (since_rst <= 3) begin
                check_value("after reset flit_out_wr", 32'd0, 32'(flit_out_wr));
                check_value("after reset credit_out", 32'd0, 32'(credit_out));
            end
            for (int p = 0; p < num_ports; p++) begin
                credit_in[p] = 1'b0;
                if (flit_out_wr[p]) begin
                    score_flit(p, flit_out[p]);
                    if (hold_on[p]) begin
                        pend_cr[p]++;
                        hold_cnt[p]++;
                    end else begin
                        credit_in[p] = 1'b1;
                    end
                end else if (!hold_on[p] && pend_cr[p] > 0) begin
                    credit_in[p] = 1'b1;  // give back withheld slots
                    pend_cr[p]--;
                end
                if (hold_on[p]) begin
                    hold_left[p]--;
                    if (hold_left[p] == 0) begin
                        check_value("back-pressure flit count", buf_depth, hold_cnt[p]);
                        hold_on[p] = 1'b0;
                    end
                end
                if (credit_out[p]) begin
                    up_credit[p]++;
                    cr_cnt[p]++;
                end
                check_value($sformatf("upstream credit in range on input %0d", p), 32'd1,
                            32'(up_credit[p] >= 0 && up_credit[p] <= buf_depth));
                if (src_q[p].size() > 0 && up_credit[p] > 0) begin
                    f = src_q[p].pop_front();
                    o = src_out[p].pop_front();
                    exp_q[o*num_ports+p].push_back(f);
                    flit_in[p]    = f;
                    flit_in_wr[p] = 1'b1;
                    up_credit[p]--;
                    wr_cnt[p]++;
                end else begin
                    flit_in_wr[p] = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle > limit) begin
            $display("timeout after %0d cycles with traffic still pending", cycle);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int dest [5][2];
        int total;
        int seq_n;
        dest = '{'{2, 2}, '{4, 1}, '{2, 0}, '{0, 3}, '{2, 5}};  // local, east, north, west, south
        for (int i = 0; i < num_ports; i++)
            for (int d = 0; d < 5; d++)
                add_row(i, dest[d][0], dest[d][1], 1, (i == 0 && d == 0) ? 4 : 2, 1'b0);
        add_row(port_local, 4, 3, 5, 20, 1'b0);  // two packets fight for east
        add_row(port_south, 5, 2, 5, 0, 1'b0);
        add_row(port_west, 2, 6, 3, 0, 1'b0);
        add_row(port_local, 2, 0, 8, 30, 1'b1);  // north output starved of credit
        for (int k = 0; k < rr_pkts; k++) begin
            add_row(port_east, 0, 2, 1, (k == 0) ? 60 : 0, 1'b0);
            add_row(port_north, 1, 4, 1, 0, 1'b0);
        end

        total = 0;
        foreach (rows[r]) begin
            total += rows[r].len;
        end
        limit = 6 * total + 300;

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n <= 1'b1;

        for (int r = 0; r < rows.size(); r++) begin
            repeat (rows[r].gap) @(posedge clk);
            queue_packet(rows[r]);
        end
        while (!all_idle()) @(posedge clk);
        repeat (4) @(posedge clk);

        for (int p = 0; p < num_ports; p++)
            check_value($sformatf("credit pulses on input %0d", p), wr_cnt[p], cr_cnt[p]);
        seq_n = src_seq[port_west].size();
        if (seq_n < 2 * rr_pkts) begin
            $display("only %0d packets left the west output", seq_n);
            errors++;
        end else begin
            for (int k = seq_n - 2 * rr_pkts + 1; k < seq_n; k++)
                check_value("round-robin alternation on west", 32'd1,
                            32'(src_seq[port_west][k] != src_seq[port_west][k-1]));
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- hw/router_two_stage.sv
`timescale 1ns/1ps

module router_two_stage #(
    parameter int buf_depth = 4
) (
    input  logic                               clk,
    input  logic                               arst_n,
    // own address, kept as ports so every router has the same RTL
    input  logic [router_pkg::coord_w-1:0]     cur_x,
    input  logic [router_pkg::coord_w-1:0]     cur_y,
    input  router_pkg::flit_t                  flit_in     [router_pkg::num_ports],
    input  logic [router_pkg::num_ports-1:0]   flit_in_wr,
    output logic [router_pkg::num_ports-1:0]   credit_out,
    output router_pkg::flit_t                  flit_out    [router_pkg::num_ports],
    output logic [router_pkg::num_ports-1:0]   flit_out_wr,
    input  logic [router_pkg::num_ports-1:0]   credit_in
);
    import router_pkg::*;

    port_sel_t            req       [num_ports];
    flit_t                head_flit [num_ports];
    logic [num_ports-1:0] head_bit;
    logic [num_ports-1:0] tail_bit;
    logic [num_ports-1:0] in_grant;
    port_sel_t            out_sel   [num_ports];

    // stage 1, buffering and route computation
    for (genvar i = 0; i < num_ports; i++) begin : g_in
        input_port #(
            .buf_depth (buf_depth)
        ) u_input_port (
            .clk        (clk),
            .arst_n     (arst_n),
            .cur_x      (cur_x),
            .cur_y      (cur_y),
            .flit_in    (flit_in[i]),
            .flit_in_wr (flit_in_wr[i]),
            .grant      (in_grant[i]),
            .req        (req[i]),
            .head_flit  (head_flit[i]),
            .credit_out (credit_out[i])
        );

        assign head_bit[i] = head_flit[i].head;
        assign tail_bit[i] = head_flit[i].tail;
    end

    switch_allocator #(
        .buf_depth (buf_depth)
    ) u_switch_allocator (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .head_bit  (head_bit),
        .tail_bit  (tail_bit),
        .credit_in (credit_in),
        .in_grant  (in_grant),
        .out_sel   (out_sel)
    );

    // stage 2, switch traversal
    crossbar u_crossbar (
        .clk         (clk),
        .arst_n      (arst_n),
        .out_sel     (out_sel),
        .in_grant    (in_grant),
        .head_flit   (head_flit),
        .flit_out    (flit_out),
        .flit_out_wr (flit_out_wr)
    );

endmodule

//--- hw/crossbar.sv
`timescale 1ns/1ps

module crossbar (
    input  logic                               clk,
    input  logic                               arst_n,
    input  router_pkg::port_sel_t              out_sel   [router_pkg::num_ports],
    input  logic [router_pkg::num_ports-1:0]   in_grant,
    input  router_pkg::flit_t                  head_flit [router_pkg::num_ports],
    output router_pkg::flit_t                  flit_out  [router_pkg::num_ports],
    output logic [router_pkg::num_ports-1:0]   flit_out_wr
);
    import router_pkg::*;

    port_sel_t in_col [num_ports];  // per output, which input is granted to it
    port_sel_t col_q  [num_ports];
    flit_t     flit_q [num_ports];

    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            for (int i = 0; i < num_ports; i++) begin
                in_col[o][i] = in_grant[i] && out_sel[i][o];
            end
        end
    end

    // switch traversal register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int o = 0; o < num_ports; o++) begin
                col_q[o] <= '0;
            end
        end else begin
            col_q <= in_col;
        end
    end

    always_ff @(posedge clk) begin
        flit_q <= head_flit;
    end

    // and-or mux per output
    always_comb begin
        logic [flit_w-1:0] acc;
        for (int o = 0; o < num_ports; o++) begin
            acc = '0;
            for (int i = 0; i < num_ports; i++) begin
                if (col_q[o][i]) begin
                    acc = acc | flit_q[i];
                end
            end
            flit_out[o]    = flit_t'(acc);
            flit_out_wr[o] = |col_q[o];
        end
    end

    for (genvar o = 0; o < num_ports; o++) begin : g_chk
        a_single_source: assert property (
            @(posedge clk) disable iff (!arst_n) $onehot0(in_col[o])
        ) else $error("crossbar: more than one input granted to output %0d", o);
    end

endmodule

//--- hw/switch_allocator.sv
`timescale 1ns/1ps

module switch_allocator #(
    parameter int buf_depth = 4
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  router_pkg::port_sel_t              req      [router_pkg::num_ports],
    input  logic [router_pkg::num_ports-1:0]   head_bit,
    input  logic [router_pkg::num_ports-1:0]   tail_bit,
    input  logic [router_pkg::num_ports-1:0]   credit_in,
    output logic [router_pkg::num_ports-1:0]   in_grant,
    output router_pkg::port_sel_t              out_sel  [router_pkg::num_ports]
);
    import router_pkg::*;

    localparam int cnt_w = $clog2(buf_depth + 1);

    // indexed by output, bits are inputs
    port_sel_t              arb_req   [num_ports];
    port_sel_t              arb_grant [num_ports];
    port_sel_t              owner     [num_ports];  // input holding the lock
    logic [num_ports-1:0]   locked;
    logic [num_ports-1:0]   granted;
    logic [num_ports-1:0]   release_out;            // tail granted, output freed
    logic [num_ports-1:0]   lock_out;               // head without tail granted
    logic [cnt_w-1:0]       credit_cnt [num_ports];

    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            for (int i = 0; i < num_ports; i++) begin
                arb_req[o][i] = req[i][o] && (!locked[o] || owner[o][i])
                                && (credit_cnt[o] != '0);
            end
        end
    end

    // back to per-input view
    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            for (int o = 0; o < num_ports; o++) begin
                out_sel[i][o] = arb_grant[o][i];
            end
            in_grant[i] = |out_sel[i];
        end
    end

    for (genvar o = 0; o < num_ports; o++) begin : g_out
        assign granted[o]     = |arb_grant[o];
        assign release_out[o] = |(arb_grant[o] & tail_bit);
        assign lock_out[o]    = |(arb_grant[o] & head_bit) && !release_out[o];

        rr_arbiter u_arb (
            .clk     (clk),
            .arst_n  (arst_n),
            .request (arb_req[o]),
            .advance (release_out[o]),  // pointer moves only between packets
            .grant   (arb_grant[o])
        );

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                locked[o] <= 1'b0;
                owner[o]  <= '0;
            end else if (release_out[o]) begin
                locked[o] <= 1'b0;
            end else if (lock_out[o]) begin
                locked[o] <= 1'b1;
                owner[o]  <= arb_grant[o];
            end
        end

        // free slots in the downstream buffer
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                credit_cnt[o] <= cnt_w'(buf_depth);
            end else begin
                case ({granted[o], credit_in[o]})
                    2'b10:   credit_cnt[o] <= credit_cnt[o] - 1'b1;
                    2'b01:   credit_cnt[o] <= credit_cnt[o] + 1'b1;
                    default: credit_cnt[o] <= credit_cnt[o];  // both or neither
                endcase
            end
        end

        a_credit_no_overflow: assert property (
            @(posedge clk) disable iff (!arst_n)
            (credit_in[o] && !granted[o]) |-> (credit_cnt[o] < cnt_w'(buf_depth))
        ) else $error("switch_allocator: credit counter overflow on output %0d", o);
    end

endmodule

//--- hw/input_port.sv
`timescale 1ns/1ps

module input_port #(
    parameter int buf_depth = 4
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [router_pkg::coord_w-1:0]     cur_x,
    input  logic [router_pkg::coord_w-1:0]     cur_y,
    input  router_pkg::flit_t                  flit_in,
    input  logic                               flit_in_wr,
    input  logic                               grant,
    output router_pkg::port_sel_t              req,
    output router_pkg::flit_t                  head_flit,
    output logic                               credit_out
);
    import router_pkg::*;

    localparam int ptr_w = $clog2(buf_depth);
    localparam int cnt_w = $clog2(buf_depth + 1);

    flit_t            mem [buf_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             empty;
    logic             full;
    logic             wr_en;
    logic             rd_en;
    port_sel_t        xy_route;  // route of the flit at the FIFO head, if it is a head
    port_sel_t        route_q;   // route held for body and tail flits

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(buf_depth));
    assign wr_en = flit_in_wr && !full;
    assign rd_en = grant && !empty;

    assign head_flit = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= flit_in;
        end
    end

    // circular pointers, depth need not be a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_w'(buf_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_w'(buf_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // dimension order, x first then y
    always_comb begin
        xy_route = '0;
        if (head_flit.body.hdr.dst_x > cur_x) begin
            xy_route[port_east] = 1'b1;
        end else if (head_flit.body.hdr.dst_x < cur_x) begin
            xy_route[port_west] = 1'b1;
        end else if (head_flit.body.hdr.dst_y > cur_y) begin
            xy_route[port_south] = 1'b1;
        end else if (head_flit.body.hdr.dst_y < cur_y) begin
            xy_route[port_north] = 1'b1;
        end else begin
            xy_route[port_local] = 1'b1;  // arrived
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            route_q    <= '0;
            credit_out <= 1'b0;
        end else begin
            if (rd_en && head_flit.head) begin
                route_q <= xy_route;
            end
            credit_out <= rd_en;  // one pulse per flit leaving the buffer
        end
    end

    always_comb begin
        if (empty) begin
            req = '0;
        end else if (head_flit.head) begin
            req = xy_route;
        end else begin
            req = route_q;
        end
    end

    // upstream must hold a credit before writing
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) flit_in_wr |-> !full
    ) else $error("input_port: flit written into a full buffer");

    a_no_grant_when_empty: assert property (
        @(posedge clk) disable iff (!arst_n) grant |-> !empty
    ) else $error("input_port: grant while buffer is empty");

endmodule

//--- hw/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter (
    input  logic                  clk,
    input  logic                  arst_n,
    input  router_pkg::port_sel_t request,
    input  logic                  advance,
    output router_pkg::port_sel_t grant
);
    import router_pkg::*;

    localparam int ptr_w = $clog2(num_ports);

    logic [ptr_w-1:0] ptr;        // requester with first priority
    logic [ptr_w-1:0] grant_idx;
    logic [ptr_w-1:0] next_ptr;

    // search from the pointer, wrapping around once
    always_comb begin
        int   idx;
        logic found;
        grant     = '0;
        grant_idx = '0;
        found     = 1'b0;
        for (int k = 0; k < num_ports; k++) begin
            idx = int'(ptr) + k;
            if (idx >= num_ports) begin
                idx = idx - num_ports;
            end
            if (!found && request[idx]) begin
                grant[idx] = 1'b1;
                grant_idx  = ptr_w'(idx);
                found      = 1'b1;
            end
        end
    end

    assign next_ptr = (grant_idx == ptr_w'(num_ports - 1)) ? '0 : grant_idx + 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (advance && (grant != '0)) begin
            ptr <= next_ptr;  // winner drops to lowest priority
        end
    end

    a_grant_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(grant) && ((grant & ~request) == '0) && ((request != '0) == (grant != '0))
    ) else $error("rr_arbiter: grant not one-hot or not requested");

endmodule

//--- hw/router_pkg.sv
package router_pkg;

    // router ports, one per mesh direction plus the local endpoint
    localparam int num_ports  = 5;
    localparam int port_local = 0;
    localparam int port_east  = 1;
    localparam int port_north = 2;
    localparam int port_west  = 3;
    localparam int port_south = 4;

    localparam int coord_w = 3;  // one mesh coordinate
    localparam int flit_w  = 32;

    localparam int body_w         = flit_w - 2;             // minus head and tail bits
    localparam int head_payload_w = body_w - 2 * coord_w;

    // one-hot port vector, used for requests and grants
    typedef logic [num_ports-1:0] port_sel_t;

    // head flit carries the destination address in its upper bits
    typedef struct packed {
        logic [coord_w-1:0]        dst_x;
        logic [coord_w-1:0]        dst_y;
        logic [head_payload_w-1:0] payload;
    } head_view_t;

    // same body word, read as address or as plain data
    typedef union packed {
        head_view_t        hdr;
        logic [body_w-1:0] data;
    } flit_body_u;

    typedef struct packed {
        logic       head;
        logic       tail;  // head and tail both set for a single-flit packet
        flit_body_u body;
    } flit_t;

endpackage
